//--- native_addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module native_addr_decoder (
    input  logic [native_soc_pkg::ADDR_W-1:0] mem_addr,
    output native_soc_pkg::slave_idx_t        slave_sel
);
    import native_soc_pkg::*;

    mem_addr_u a;
    logic      timer_hit;

    assign a = mem_addr;

    // exact word match on one of the timer registers
    // misaligned or past the last word falls through to gpio
    assign timer_hit = (a.regs.block == TIMER_BASE[ADDR_W-1:5])
                    && (a.regs.word < 3'(TIMER_REGS))
                    && (a.regs.byte_off == 2'b00);

    ////////////////////
    // region decode
    ////////////////////
    always_comb begin
        if (a.rgn.region < PERIPH_BASE[ADDR_W-1 -: 2]) begin
            // low window, boot ram
            slave_sel = SLV_BOOT;
        end else if (a.rgn.region < DDR_BASE[ADDR_W-1 -: 2]) begin
            // peripheral window
            if (timer_hit) begin
                slave_sel = SLV_TIMER;
            end else begin
                slave_sel = SLV_GPIO;
            end
        end else begin
            // everything from ddr base up
            slave_sel = SLV_DDR;
        end
    end

endmodule

`default_nettype wire

//--- native_gpio.sv
`timescale 1ns/1ps
`default_nettype none

module native_gpio (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [native_soc_pkg::ADDR_W-1:0] addr,
    input  logic [native_soc_pkg::DATA_W-1:0] wdata,
    input  logic [native_soc_pkg::STRB_W-1:0] wstrb,
    input  logic                              valid,
    input  logic [native_soc_pkg::DATA_W-1:0] gpio_in,
    output logic [native_soc_pkg::DATA_W-1:0] rdata,
    output logic                              ready,
    output logic [native_soc_pkg::DATA_W-1:0] gpio_out
);
    import native_soc_pkg::*;

    logic              acc;
    logic              sel_in;
    logic [DATA_W-1:0] in_q;

    assign acc = valid && !ready;
    // offset 4 is the input word, offset 0 the output word
    assign sel_in = addr[2];

    ////////////////////
    // output register
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ready    <= 1'b0;
            gpio_out <= '0;
        end else begin
            ready <= acc;
            if (acc && !sel_in && wstrb != '0) begin
                gpio_out <= strb_merge(gpio_out, wdata, wstrb);
            end
        end
    end

    // input sampling and read data
    always_ff @(posedge clk) begin
        in_q <= gpio_in;
        if (acc) begin
            // input word is read only, writes there are dropped
            rdata <= sel_in ? in_q : gpio_out;
        end
    end

    a_ready_valid: assert property (@(posedge clk) disable iff (rst) ready |-> valid)
        else $error("gpio ready without valid");

endmodule

`default_nettype wire

//--- native_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module native_interconnect (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              mem_select,
    // master side
    input  logic [native_soc_pkg::ADDR_W-1:0] m_addr,
    input  logic [native_soc_pkg::DATA_W-1:0] m_wdata,
    input  logic [native_soc_pkg::STRB_W-1:0] m_wstrb,
    input  logic                              m_valid,
    output logic [native_soc_pkg::DATA_W-1:0] m_rdata,
    output logic                              m_ready,
    output native_soc_pkg::slave_idx_t        slave_select,
    // slave 0
    output logic [native_soc_pkg::ADDR_W-1:0] s_addr_0,
    output logic [native_soc_pkg::DATA_W-1:0] s_wdata_0,
    output logic [native_soc_pkg::STRB_W-1:0] s_wstrb_0,
    output logic                              s_valid_0,
    input  logic [native_soc_pkg::DATA_W-1:0] s_rdata_0,
    input  logic                              s_ready_0,
    // slave 1
    output logic [native_soc_pkg::ADDR_W-1:0] s_addr_1,
    output logic [native_soc_pkg::DATA_W-1:0] s_wdata_1,
    output logic [native_soc_pkg::STRB_W-1:0] s_wstrb_1,
    output logic                              s_valid_1,
    input  logic [native_soc_pkg::DATA_W-1:0] s_rdata_1,
    input  logic                              s_ready_1,
    // slave 2
    output logic [native_soc_pkg::ADDR_W-1:0] s_addr_2,
    output logic [native_soc_pkg::DATA_W-1:0] s_wdata_2,
    output logic [native_soc_pkg::STRB_W-1:0] s_wstrb_2,
    output logic                              s_valid_2,
    input  logic [native_soc_pkg::DATA_W-1:0] s_rdata_2,
    input  logic                              s_ready_2,
    // slave 3
    output logic [native_soc_pkg::ADDR_W-1:0] s_addr_3,
    output logic [native_soc_pkg::DATA_W-1:0] s_wdata_3,
    output logic [native_soc_pkg::STRB_W-1:0] s_wstrb_3,
    output logic                              s_valid_3,
    input  logic [native_soc_pkg::DATA_W-1:0] s_rdata_3,
    input  logic                              s_ready_3
);
    import native_soc_pkg::*;

    slave_idx_t dec_sel;
    slave_idx_t phys_sel;

    native_addr_decoder i_dec (
        .mem_addr  (m_addr),
        .slave_sel (dec_sel)
    );

    // reported index is the decoded one before the swap
    assign slave_select = dec_sel;

    // mem_select exchanges boot and ddr windows
    always_comb begin
        phys_sel = dec_sel;
        if (mem_select) begin
            if (dec_sel == SLV_BOOT) begin
                phys_sel = SLV_DDR;
            end else if (dec_sel == SLV_DDR) begin
                phys_sel = SLV_BOOT;
            end
        end
    end

    ////////////////////
    // request steering
    ////////////////////
    always_comb begin
        // idle slaves see all zeros
        {s_addr_3, s_addr_2, s_addr_1, s_addr_0}     = '0;
        {s_wdata_3, s_wdata_2, s_wdata_1, s_wdata_0} = '0;
        {s_wstrb_3, s_wstrb_2, s_wstrb_1, s_wstrb_0} = '0;
        {s_valid_3, s_valid_2, s_valid_1, s_valid_0} = '0;
        case (phys_sel)
            SLV_BOOT: begin
                s_addr_0  = m_addr;
                s_wdata_0 = m_wdata;
                s_wstrb_0 = m_wstrb;
                s_valid_0 = m_valid;
            end
            SLV_DDR: begin
                s_addr_1  = m_addr;
                s_wdata_1 = m_wdata;
                s_wstrb_1 = m_wstrb;
                s_valid_1 = m_valid;
            end
            SLV_TIMER: begin
                s_addr_2  = m_addr;
                s_wdata_2 = m_wdata;
                s_wstrb_2 = m_wstrb;
                s_valid_2 = m_valid;
            end
            default: begin
                s_addr_3  = m_addr;
                s_wdata_3 = m_wdata;
                s_wstrb_3 = m_wstrb;
                s_valid_3 = m_valid;
            end
        endcase
    end

    ////////////////////
    // response return
    ////////////////////
    always_comb begin
        case (phys_sel)
            SLV_BOOT: begin
                m_rdata = s_rdata_0;
                m_ready = s_ready_0;
            end
            SLV_DDR: begin
                m_rdata = s_rdata_1;
                m_ready = s_ready_1;
            end
            SLV_TIMER: begin
                m_rdata = s_rdata_2;
                m_ready = s_ready_2;
            end
            default: begin
                m_rdata = s_rdata_3;
                m_ready = s_ready_3;
            end
        endcase
    end

    // never two slaves answering in the same cycle
    a_one_ready: assert property (@(posedge clk) disable iff (rst)
        $onehot0({s_ready_3, s_ready_2, s_ready_1, s_ready_0}))
        else $error("more than one slave ready");

endmodule

`default_nettype wire

//--- native_mem_subsys.f
native_soc_pkg.sv
native_addr_decoder.sv
native_interconnect.sv
native_sram.sv
native_timer_regs.sv
native_gpio.sv
native_mem_subsys.sv
tb_clock_gen.sv
tb_native_mem_subsys.sv

//--- native_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module native_mem_subsys #(
    parameter int BOOT_WORDS = 1024,
    parameter int BOOT_WAIT  = 0,
    parameter int DDR_WORDS  = 4096,
    parameter int DDR_WAIT   = 3
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              mem_select,
    // master port
    input  logic [native_soc_pkg::ADDR_W-1:0] m_addr,
    input  logic [native_soc_pkg::DATA_W-1:0] m_wdata,
    input  logic [native_soc_pkg::STRB_W-1:0] m_wstrb,
    input  logic                              m_valid,
    output logic [native_soc_pkg::DATA_W-1:0] m_rdata,
    output logic                              m_ready,
    output native_soc_pkg::slave_idx_t        slave_select,
    // peripheral pins
    output logic                              irq,
    input  logic [native_soc_pkg::DATA_W-1:0] gpio_in,
    output logic [native_soc_pkg::DATA_W-1:0] gpio_out
);
    import native_soc_pkg::*;

    // slave side of the interconnect
    logic [ADDR_W-1:0] s_addr_0, s_addr_1, s_addr_2, s_addr_3;
    logic [DATA_W-1:0] s_wdata_0, s_wdata_1, s_wdata_2, s_wdata_3;
    logic [STRB_W-1:0] s_wstrb_0, s_wstrb_1, s_wstrb_2, s_wstrb_3;
    logic              s_valid_0, s_valid_1, s_valid_2, s_valid_3;
    logic [DATA_W-1:0] s_rdata_0, s_rdata_1, s_rdata_2, s_rdata_3;
    logic              s_ready_0, s_ready_1, s_ready_2, s_ready_3;

    // port names match one to one
    native_interconnect i_ic (.*);

    ////////////////////
    // slave 0, boot ram
    ////////////////////
    native_sram #(
        .DEPTH_WORDS (BOOT_WORDS),
        .WAIT_CYCLES (BOOT_WAIT)
    ) i_boot (
        .clk   (clk),
        .rst   (rst),
        .addr  (s_addr_0),
        .wdata (s_wdata_0),
        .wstrb (s_wstrb_0),
        .valid (s_valid_0),
        .rdata (s_rdata_0),
        .ready (s_ready_0)
    );

    // slave 1, slow ddr stand-in
    native_sram #(
        .DEPTH_WORDS (DDR_WORDS),
        .WAIT_CYCLES (DDR_WAIT)
    ) i_ddr (
        .clk   (clk),
        .rst   (rst),
        .addr  (s_addr_1),
        .wdata (s_wdata_1),
        .wstrb (s_wstrb_1),
        .valid (s_valid_1),
        .rdata (s_rdata_1),
        .ready (s_ready_1)
    );

    ////////////////////
    // peripherals
    ////////////////////
    native_timer_regs i_timer (
        .clk   (clk),
        .rst   (rst),
        .addr  (s_addr_2),
        .wdata (s_wdata_2),
        .wstrb (s_wstrb_2),
        .valid (s_valid_2),
        .rdata (s_rdata_2),
        .ready (s_ready_2),
        .irq   (irq)
    );

    native_gpio i_gpio (
        .clk      (clk),
        .rst      (rst),
        .addr     (s_addr_3),
        .wdata    (s_wdata_3),
        .wstrb    (s_wstrb_3),
        .valid    (s_valid_3),
        .gpio_in  (gpio_in),
        .rdata    (s_rdata_3),
        .ready    (s_ready_3),
        .gpio_out (gpio_out)
    );

endmodule

`default_nettype wire

//--- native_soc_pkg.sv
`default_nettype none

package native_soc_pkg;

    ////////////////////
    // bus widths
    ////////////////////
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    ////////////////////
    // memory map
    ////////////////////
    localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h4000_0000;
    localparam logic [ADDR_W-1:0] TIMER_BASE  = 32'h7000_0000;
    localparam logic [ADDR_W-1:0] DDR_BASE    = 32'h8000_0000;
    // timer words at base + 0x00 up to base + 0x10
    localparam int TIMER_REGS = 5;

    // decoded target, numbered like the slave ports
    typedef enum logic [1:0] {
        SLV_BOOT  = 2'd0,
        SLV_DDR   = 2'd1,
        SLV_TIMER = 2'd2,
        SLV_GPIO  = 2'd3
    } slave_idx_t;

    // one address word, read two ways
    typedef union packed {
        // top two bits pick the 1 GB window
        struct packed {
            logic [1:0]  region;
            logic [29:0] offset;
        } rgn;
        // small register blocks, 8 words each
        struct packed {
            logic [26:0] block;
            logic [2:0]  word;
            logic [1:0]  byte_off;
        } regs;
    } mem_addr_u;

    // byte-lane merge of a write into an old word
    function automatic logic [DATA_W-1:0] strb_merge(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] new_val,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] res;
        res = old_val;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- native_sram.sv
`timescale 1ns/1ps
`default_nettype none

module native_sram #(
    parameter int DEPTH_WORDS = 1024,
    parameter int WAIT_CYCLES = 0
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [native_soc_pkg::ADDR_W-1:0] addr,
    input  logic [native_soc_pkg::DATA_W-1:0] wdata,
    input  logic [native_soc_pkg::STRB_W-1:0] wstrb,
    input  logic                              valid,
    output logic [native_soc_pkg::DATA_W-1:0] rdata,
    output logic                              ready
);
    import native_soc_pkg::*;

    localparam int IDX_W = $clog2(DEPTH_WORDS);
    localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(WAIT_CYCLES);

    logic [DATA_W-1:0] mem [DEPTH_WORDS];
    logic [IDX_W-1:0]  idx;
    logic [CNT_W-1:0]  wait_cnt;
    logic              fire;

    // word index wraps at the depth
    assign idx = addr[IDX_W+1:2];

    // last wait cycle of a live request
    assign fire = valid && !ready && (wait_cnt == LAST);

    ////////////////////
    // wait counter
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ready    <= 1'b0;
            wait_cnt <= '0;
        end else begin
            ready <= fire;
            // restart on drop of valid or after the pulse
            if (!valid || ready || fire) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // storage, read before write on the same edge
    always_ff @(posedge clk) begin
        if (fire) begin
            rdata <= mem[idx];
            if (wstrb != '0) begin
                mem[idx] <= strb_merge(mem[idx], wdata, wstrb);
            end
        end
    end

    a_ready_valid: assert property (@(posedge clk) disable iff (rst) ready |-> valid)
        else $error("sram ready without valid");

endmodule

`default_nettype wire

//--- native_timer_regs.sv
`timescale 1ns/1ps
`default_nettype none

module native_timer_regs (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [native_soc_pkg::ADDR_W-1:0] addr,
    input  logic [native_soc_pkg::DATA_W-1:0] wdata,
    input  logic [native_soc_pkg::STRB_W-1:0] wstrb,
    input  logic                              valid,
    output logic [native_soc_pkg::DATA_W-1:0] rdata,
    output logic                              ready,
    output logic                              irq
);
    import native_soc_pkg::*;

    // register word offsets
    localparam logic [2:0] W_CTRL    = 3'd0;
    localparam logic [2:0] W_COUNT   = 3'd1;
    localparam logic [2:0] W_COMPARE = 3'd2;
    localparam logic [2:0] W_STATUS  = 3'd3;
    localparam logic [2:0] W_SCRATCH = 3'd4;

    mem_addr_u         a;
    logic [2:0]        word;
    logic              acc;
    logic              wr;
    logic              en;
    logic              match_flg;
    logic [DATA_W-1:0] count;
    logic [DATA_W-1:0] compare;
    logic [DATA_W-1:0] scratch;

    assign a    = addr;
    assign word = a.regs.word;
    assign acc  = valid && !ready;
    assign wr   = acc && (wstrb != '0);
    assign irq  = match_flg;

    ////////////////////
    // control state
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ready     <= 1'b0;
            en        <= 1'b0;
            count     <= '0;
            match_flg <= 1'b0;
        end else begin
            ready <= acc;
            if (wr && word == W_CTRL && wstrb[0]) begin
                en <= wdata[0];
            end
            // bus write beats the increment
            if (wr && word == W_COUNT) begin
                count <= strb_merge(count, wdata, wstrb);
            end else if (en) begin
                count <= count + 1'b1;
            end
            // sticky flag where a new match wins over the clear
            if (en && count == compare) begin
                match_flg <= 1'b1;
            end else if (wr && word == W_STATUS && wstrb[0] && wdata[0]) begin
                match_flg <= 1'b0;
            end
        end
    end

    // compare, scratch and read data
    always_ff @(posedge clk) begin
        if (wr && word == W_COMPARE) begin
            compare <= strb_merge(compare, wdata, wstrb);
        end
        if (wr && word == W_SCRATCH) begin
            scratch <= strb_merge(scratch, wdata, wstrb);
        end
        if (acc) begin
            case (word)
                W_CTRL:    rdata <= {{(DATA_W-1){1'b0}}, en};
                W_COUNT:   rdata <= count;
                W_COMPARE: rdata <= compare;
                W_STATUS:  rdata <= {{(DATA_W-1){1'b0}}, match_flg};
                W_SCRATCH: rdata <= scratch;
                default:   rdata <= '0;
            endcase
        end
    end

    // response only while the request is still held
    a_ready_valid: assert property (@(posedge clk) disable iff (rst)
        ready |-> valid)
        else $error("timer ready without valid");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator, status follows the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_native_mem_subsys -f native_mem_subsys.f || exit 1
out=$(./obj_dir/Vtb_native_mem_subsys 2>&1)
echo "$out"
echo "$out" | grep -qx "Test passed" && echo "run_sim: ok" || { echo "run_sim: failing"; exit 1; }

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free running clock for the testbench
module tb_clock_gen #(
    parameter int HALF_NS = 4
) (
    output logic clk
);

    // starts low, first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_NS) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- tb_native_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_native_mem_subsys;

    localparam int BOOT_WORDS = 1024;
    localparam int DDR_WORDS  = 4096;
    localparam int N_ADDR     = 8;
    localparam int N_RAND     = 24;
    localparam logic [31:0] SEED   = 32'ha0bdca6a;
    localparam logic [31:0] T_BASE = 32'h7000_0000;
    localparam logic [31:0] G_BASE = 32'h4000_0000;

    logic        clk;
    logic        rst;
    logic        mem_select;
    logic [31:0] m_addr;
    logic [31:0] m_wdata;
    logic [3:0]  m_wstrb;
    logic        m_valid;
    logic [31:0] m_rdata;
    logic        m_ready;
    logic [1:0]  slave_select;
    logic        irq;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;

    // expected response of the request in flight
    logic [31:0] exp_rdata;
    logic [1:0]  exp_sel;
    logic        chk_rd;

    // reference models
    logic [31:0] boot_model [BOOT_WORDS];
    logic [31:0] ddr_model  [DDR_WORDS];
    logic [31:0] boot_addr  [N_ADDR];
    logic [31:0] ddr_addr   [N_ADDR];
    logic [31:0] gpio_exp;
    logic [31:0] scratch_exp;
    logic [31:0] lfsr_state;
    int          n_issued;
    int          cycle_cnt = 0;

    tb_clock_gen i_clk (.clk(clk));

    native_mem_subsys #(
        .BOOT_WORDS (BOOT_WORDS),
        .BOOT_WAIT  (0),
        .DDR_WORDS  (DDR_WORDS),
        .DDR_WAIT   (3)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .mem_select   (mem_select),
        .m_addr       (m_addr),
        .m_wdata      (m_wdata),
        .m_wstrb      (m_wstrb),
        .m_valid      (m_valid),
        .m_rdata      (m_rdata),
        .m_ready      (m_ready),
        .slave_select (slave_select),
        .irq          (irq),
        .gpio_in      (gpio_in),
        .gpio_out     (gpio_out)
    );

    ////////////////////
    // helpers
    ////////////////////
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic logic [3:0] rand_strobe();
        logic [3:0] s;
        s = 4'(take_bits(4));
        // all zero would turn the write into a read
        if (s == 4'h0) begin
            s = 4'hF;
        end
        return s;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  strb);
        logic [31:0] r;
        r = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                r[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return r;
    endfunction

    // memory map as seen by the master, no swap
    function automatic logic [1:0] decode_rule(input logic [31:0] a);
        if (a < 32'h4000_0000) begin
            return 2'd0;
        end
        if (a >= 32'h8000_0000) begin
            return 2'd1;
        end
        if (a >= 32'h7000_0000 && a <= 32'h7000_0010 && a[1:0] == 2'b00) begin
            return 2'd2;
        end
        return 2'd3;
    endfunction

    // low window lands in boot ram unless swapped
    function automatic bit boot_side(input logic [31:0] a);
        return (a < 32'h4000_0000) ^ mem_select;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] a);
        if (boot_side(a)) begin
            return boot_model[int'(a[31:2]) % BOOT_WORDS];
        end
        return ddr_model[int'(a[31:2]) % DDR_WORDS];
    endfunction

    ////////////////////
    // bus tasks
    ////////////////////
    // one request, held until ready, then one idle cycle
    task automatic bus_request(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] strb, input bit check,
                               input logic [31:0] expect_val);
        @(negedge clk);
        m_addr    = addr;
        m_wdata   = wdata;
        m_wstrb   = strb;
        m_valid   = 1'b1;
        exp_sel   = decode_rule(addr);
        exp_rdata = expect_val;
        chk_rd    = check;
        n_issued  = n_issued + 1;
        do @(negedge clk); while (!m_ready);
        // valid stays up across the ready edge
        @(negedge clk);
        m_valid = 1'b0;
        m_wstrb = 4'h0;
        chk_rd  = 1'b0;
    endtask

    task automatic mem_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        int idx;
        if (boot_side(addr)) begin
            idx = int'(addr[31:2]) % BOOT_WORDS;
            boot_model[idx] = merge_bytes(boot_model[idx], data, strb);
        end else begin
            idx = int'(addr[31:2]) % DDR_WORDS;
            ddr_model[idx] = merge_bytes(ddr_model[idx], data, strb);
        end
        bus_request(addr, data, strb, 1'b0, 32'h0);
    endtask

    task automatic mem_check(input logic [31:0] addr);
        bus_request(addr, 32'h0, 4'h0, 1'b1, model_read(addr));
    endtask

    ////////////////////
    // checkers
    ////////////////////
    a_rdata: assert property (@(posedge clk) disable iff (rst)
        (m_ready && chk_rd) |-> (m_rdata == exp_rdata))
        else fail_run($sformatf("FAILED at %0t: m_rdata expected %08h got %08h",
                                $time, $sampled(exp_rdata), $sampled(m_rdata)));

    a_sel: assert property (@(posedge clk) disable iff (rst)
        m_ready |-> (slave_select == exp_sel))
        else fail_run($sformatf("FAILED at %0t: slave_select expected %0d got %0d",
                                $time, $sampled(exp_sel), $sampled(slave_select)));

    a_ready_valid: assert property (@(posedge clk) disable iff (rst) m_ready |-> m_valid)
        else fail_run("m_ready was high while m_valid was low");

    // budget grows with each request issued
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > 40 * n_issued + 200) begin
            fail_run($sformatf("timeout, no progress after %0d cycles and %0d requests",
                               cycle_cnt, n_issued));
        end
    end

    ////////////////////
    // stimulus
    ////////////////////
    initial begin
        rst        = 1'b1;
        mem_select = 1'b0;
        m_addr     = '0;
        m_wdata    = '0;
        m_wstrb    = '0;
        m_valid    = 1'b0;
        gpio_in    = '0;
        exp_rdata  = '0;
        exp_sel    = '0;
        chk_rd     = 1'b0;
        n_issued   = 0;
        lfsr_state = SEED;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // boot ram, full words first so no x is read back
        for (int i = 0; i < N_ADDR; i++) begin
            boot_addr[i] = {2'b00, 28'(take_bits(28)), 2'b00};
            mem_write(boot_addr[i], take_bits(32), 4'hF);
        end
        for (int i = 0; i < N_ADDR; i++) begin
            mem_write(boot_addr[i], take_bits(32), rand_strobe());
        end
        for (int i = 0; i < N_ADDR; i++) begin
            mem_check(boot_addr[i]);
        end

        // ddr window, slow slave
        for (int i = 0; i < N_ADDR; i++) begin
            ddr_addr[i] = {1'b1, 29'(take_bits(29)), 2'b00};
            mem_write(ddr_addr[i], take_bits(32), 4'hF);
        end
        for (int i = 0; i < N_ADDR; i++) begin
            mem_write(ddr_addr[i], take_bits(32), rand_strobe());
        end
        for (int i = 0; i < N_ADDR; i++) begin
            mem_check(ddr_addr[i]);
        end

        // swapped, boot data through the high window and back
        mem_select = 1'b1;
        for (int i = 0; i < N_ADDR; i++) begin
            mem_check({1'b1, 19'(take_bits(19)), boot_addr[i][11:2], 2'b00});
        end
        for (int i = 0; i < N_ADDR; i++) begin
            mem_check({2'b00, 16'(take_bits(16)), ddr_addr[i][13:2], 2'b00});
        end
        for (int i = 0; i < N_ADDR; i++) begin
            mem_write({1'b1, 19'(take_bits(19)), boot_addr[i][11:2], 2'b00},
                      take_bits(32), rand_strobe());
        end
        mem_select = 1'b0;
        for (int i = 0; i < N_ADDR; i++) begin
            mem_check(boot_addr[i]);
        end

        // decode edges, timer words and their neighbours
        foreach (ddr_addr[i]) begin
            bus_request(T_BASE + 32'(4 * i), 32'h0, 4'h0, 1'b0, 32'h0);
        end
        bus_request(32'h6FFF_FFFC, 32'h0, 4'h0, 1'b0, 32'h0);
        bus_request(32'h7000_0002, 32'h0, 4'h0, 1'b0, 32'h0);
        bus_request(32'h3FFF_FFFC, 32'h0, 4'h0, 1'b0, 32'h0);
        bus_request(32'h7FFF_FFFC, 32'h0, 4'h0, 1'b0, 32'h0);
        // random reads, a quarter aimed near the timer
        for (int i = 0; i < N_RAND; i++) begin
            logic [31:0] a;
            mem_select = take_bits(1) != 32'h0;
            if (take_bits(2) == 32'h0) begin
                a = T_BASE | (take_bits(3) << 2);
            end else begin
                a = take_bits(32);
            end
            bus_request(a, 32'h0, 4'h0, 1'b0, 32'h0);
        end
        mem_select = 1'b0;

        ////////////////////
        // timer
        ////////////////////
        scratch_exp = take_bits(32);
        bus_request(T_BASE + 32'h10, scratch_exp, 4'hF, 1'b0, 32'h0);
        bus_request(T_BASE + 32'h10, 32'h0, 4'h0, 1'b1, scratch_exp);
        begin
            logic [31:0] d;
            logic [3:0]  s;
            d = take_bits(32);
            s = rand_strobe();
            scratch_exp = merge_bytes(scratch_exp, d, s);
            bus_request(T_BASE + 32'h10, d, s, 1'b0, 32'h0);
        end
        bus_request(T_BASE + 32'h10, 32'h0, 4'h0, 1'b1, scratch_exp);
        // count 0, compare 10 ahead, then enable
        bus_request(T_BASE + 32'h04, 32'h0, 4'hF, 1'b0, 32'h0);
        bus_request(T_BASE + 32'h08, 32'd10, 4'hF, 1'b0, 32'h0);
        assert (!irq) else fail_run("irq was high before the timer was enabled");
        bus_request(T_BASE, 32'h1, 4'hF, 1'b0, 32'h0);
        for (int c = 0; c < 20 && !irq; c++) begin
            @(negedge clk);
        end
        assert (irq) else fail_run("irq did not rise within 20 cycles of enabling the timer");
        bus_request(T_BASE + 32'h0C, 32'h0, 4'h0, 1'b1, 32'h1);
        // stop the count, then clear the sticky flag
        bus_request(T_BASE, 32'h0, 4'hF, 1'b0, 32'h0);
        bus_request(T_BASE + 32'h0C, 32'h1, 4'hF, 1'b0, 32'h0);
        assert (!irq) else fail_run("irq stayed high after writing 1 to the status flag");
        bus_request(T_BASE + 32'h0C, 32'h0, 4'h0, 1'b1, 32'h0);
        bus_request(T_BASE, 32'h0, 4'h0, 1'b1, 32'h0);

        ////////////////////
        // gpio
        ////////////////////
        gpio_exp = '0;
        for (int i = 0; i < 6; i++) begin
            logic [31:0] d;
            logic [3:0]  s;
            d = take_bits(32);
            s = rand_strobe();
            gpio_exp = merge_bytes(gpio_exp, d, s);
            bus_request(G_BASE, d, s, 1'b0, 32'h0);
            assert (gpio_out == gpio_exp)
                else fail_run($sformatf("FAILED at %0t: gpio_out expected %08h got %08h",
                                        $time, gpio_exp, gpio_out));
            bus_request(G_BASE, 32'h0, 4'h0, 1'b1, gpio_exp);
        end
        // input word, held two cycles before the read
        for (int i = 0; i < 4; i++) begin
            gpio_in = take_bits(32);
            repeat (2) @(negedge clk);
            bus_request(G_BASE + 32'h4, 32'h0, 4'h0, 1'b1, gpio_in);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
